/* common/armStatusPkg.sv */
package armStatusPkg;

  // Status word geometry
  localparam int statusWidth = 12;                 // Flags, disables, Thumb, mode
  localparam int flagsWidth  = 4;                  // N Z C V
  localparam int modeWidth   = 5;                  // ARM mode field
  localparam int excCount    = 6;                  // Exception kinds in request word

  // Field positions inside the status word
  localparam int flagsLsb  = 8;                    // Flags occupy 11:8
  localparam int irqDisBit = 7;                    // I bit
  localparam int fiqDisBit = 6;                    // F bit
  localparam int thumbBit  = 5;                    // T bit

  // Flag positions inside the 4-bit flag field
  localparam int nFlag = 3;                        // Negative
  localparam int zFlag = 2;                        // Zero
  localparam int cFlag = 1;                        // Carry
  localparam int vFlag = 0;                        // Overflow

  // Mode codes
  localparam logic [modeWidth-1:0] modeUser  = 5'b10000;
  localparam logic [modeWidth-1:0] modeFiq   = 5'b10001;
  localparam logic [modeWidth-1:0] modeIrq   = 5'b10010;
  localparam logic [modeWidth-1:0] modeSvc   = 5'b10011;
  localparam logic [modeWidth-1:0] modeAbort = 5'b10111;
  localparam logic [modeWidth-1:0] modeUndef = 5'b11011;

  // Bit positions in the request word, top bit down
  localparam int excFiq      = 5;
  localparam int excIrq      = 4;
  localparam int excUndef    = 3;
  localparam int excPrefetch = 2;
  localparam int excData     = 1;
  localparam int excSwi      = 0;

  // Vector offsets from the table base
  localparam logic [7:0] vecReset    = 8'h00;
  localparam logic [7:0] vecUndef    = 8'h04;
  localparam logic [7:0] vecSwi      = 8'h08;
  localparam logic [7:0] vecPrefetch = 8'h0C;
  localparam logic [7:0] vecData     = 8'h10;
  localparam logic [7:0] vecIrq      = 8'h18;
  localparam logic [7:0] vecFiq      = 8'h1C;

  // Banked saved registers and their slots
  localparam int savedCount = 5;                   // svc, abort, undef, irq, fiq
  localparam int savedIdxWidth = 3;                // Enough for five slots
  localparam logic [savedIdxWidth-1:0] savedSvc   = 3'd0;
  localparam logic [savedIdxWidth-1:0] savedAbort = 3'd1;
  localparam logic [savedIdxWidth-1:0] savedUndef = 3'd2;
  localparam logic [savedIdxWidth-1:0] savedIrq   = 3'd3;
  localparam logic [savedIdxWidth-1:0] savedFiq   = 3'd4;

endpackage

/* hdl/exceptionPrioritizer.sv */
module exceptionPrioritizer
  import armStatusPkg::*;
(
  input  logic [excCount-1:0] excRequest,   // One bit per exception kind
  input  logic                irqDisable,   // I bit of current status
  input  logic                fiqDisable,   // F bit of current status
  output logic [excCount-1:0] excSelect,    // One-hot winner
  output logic                excTaken,     // Any winner this cycle
  output logic [7:0]          excVector     // Offset of winner
);

  logic [excCount-1:0] excLive;              // Requests surviving the masks

  // Interrupts blanked by their disable bits
  always_comb begin
    excLive = excRequest;
    if (irqDisable) begin
      excLive[excIrq] = 1'b0;               // IRQ held off
    end
    if (fiqDisable) begin
      excLive[excFiq] = 1'b0;               // FIQ held off
    end
  end

  // Fixed ranking, highest first
  always_comb begin
    excSelect = '0;
    excVector = vecReset;                   // Shown when nothing pending
    if (excLive[excData]) begin
      excSelect[excData] = 1'b1;            // Data abort beats all
      excVector          = vecData;
    end else if (excLive[excFiq]) begin
      excSelect[excFiq] = 1'b1;
      excVector         = vecFiq;
    end else if (excLive[excIrq]) begin
      excSelect[excIrq] = 1'b1;
      excVector         = vecIrq;
    end else if (excLive[excPrefetch]) begin
      excSelect[excPrefetch] = 1'b1;
      excVector              = vecPrefetch;
    end else if (excLive[excUndef]) begin
      excSelect[excUndef] = 1'b1;
      excVector           = vecUndef;
    end else if (excLive[excSwi]) begin
      excSelect[excSwi] = 1'b1;             // SWI lowest
      excVector         = vecSwi;
    end
  end

  assign excTaken = |excSelect;             // At most one bit set

endmodule

/* statusRegs/statusRegs.sv */
module statusRegs
  import armStatusPkg::*;
(
  input  logic                   clk,
  input  logic                   reset,
  input  logic [excCount-1:0]    excSelect,     // One-hot from prioritizer
  input  logic                   excTaken,      // Entry this cycle
  input  logic [flagsWidth-1:0]  flagsNext,     // New N Z C V
  input  logic                   flagsEnable,   // Flag load level
  input  logic                   readSaved,     // View saved reg of current mode
  input  logic                   restoreSaved,  // Exception return pulse
  output logic [statusWidth-1:0] status,        // Live current status
  output logic [statusWidth-1:0] statusData     // Selected view
);

  logic [statusWidth-1:0]   saved [savedCount];  // Banked SPSRs
  logic [modeWidth-1:0]     curMode;             // Mode field of status
  logic [savedIdxWidth-1:0] curIdx;              // Slot of current mode
  logic                     curHasSaved;         // False in user mode
  logic [modeWidth-1:0]     entryMode;           // Mode for taken exception
  logic [savedIdxWidth-1:0] entryIdx;            // Slot written on entry
  logic                     entryFiqDis;         // F bit after entry
  logic [statusWidth-1:0]   entryStatus;         // Status after entry
  logic [statusWidth-1:0]   savedView;           // Saved reg of current mode

  assign curMode = status[modeWidth-1:0];

  // Current mode to bank slot
  always_comb begin
    curIdx      = savedSvc;
    curHasSaved = 1'b1;
    case (curMode)
      modeSvc:   curIdx = savedSvc;
      modeAbort: curIdx = savedAbort;
      modeUndef: curIdx = savedUndef;
      modeIrq:   curIdx = savedIrq;
      modeFiq:   curIdx = savedFiq;
      default:   curHasSaved = 1'b0;       // User and unbanked modes
    endcase
  end

  // Target mode from the one-hot word, no ranking here
  always_comb begin
    entryMode   = curMode;
    entryIdx    = curIdx;
    entryFiqDis = status[fiqDisBit];        // F kept unless FIQ entry
    unique case (1'b1)
      excSelect[excData],
      excSelect[excPrefetch]: begin
        entryMode = modeAbort;              // Both aborts share a bank
        entryIdx  = savedAbort;
      end
      excSelect[excFiq]: begin
        entryMode   = modeFiq;
        entryIdx    = savedFiq;
        entryFiqDis = 1'b1;                 // FIQ masks further FIQs
      end
      excSelect[excIrq]: begin
        entryMode = modeIrq;
        entryIdx  = savedIrq;
      end
      excSelect[excUndef]: begin
        entryMode = modeUndef;
        entryIdx  = savedUndef;
      end
      excSelect[excSwi]: begin
        entryMode = modeSvc;
        entryIdx  = savedSvc;
      end
      default: ;                            // No exception selected
    endcase
  end

  // Flags kept, I set, T cleared
  always_comb begin
    entryStatus                = status;
    entryStatus[irqDisBit]     = 1'b1;
    entryStatus[fiqDisBit]     = entryFiqDis;
    entryStatus[thumbBit]      = 1'b0;
    entryStatus[modeWidth-1:0] = entryMode;
  end

  assign savedView = saved[curIdx];

  // Current status, priority exception > restore > flags
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      status                 <= '0;
      status[irqDisBit]      <= 1'b1;       // Start with both interrupts off
      status[fiqDisBit]      <= 1'b1;
      status[modeWidth-1:0]  <= modeSvc;    // Supervisor after reset
    end else if (excTaken) begin
      status <= entryStatus;
    end else if (restoreSaved) begin
      if (curHasSaved) begin
        status <= savedView;                // User mode ignores return
      end
    end else if (flagsEnable) begin
      status[flagsLsb +: flagsWidth] <= flagsNext;  // Only N Z C V change
    end
  end

  // Bank write on entry only
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < savedCount; i++) begin
        saved[i] <= '0;
      end
    end else if (excTaken) begin
      saved[entryIdx] <= status;            // Old status into target bank
    end
  end

  // Combinational view, no register stage
  assign statusData = (readSaved && curHasSaved) ? savedView : status;

endmodule

/* hdl/conditionCheck.sv */
module conditionCheck
  import armStatusPkg::*;
(
  input  logic [flagsWidth-1:0] flags,     // N Z C V from status
  input  logic [3:0]            cond,      // Instruction condition field
  output logic                  condPass   // Condition holds
);

  logic flagN;
  logic flagZ;
  logic flagC;
  logic flagV;
  logic nEqV;                               // Signed compare helper

  assign flagN = flags[nFlag];
  assign flagZ = flags[zFlag];
  assign flagC = flags[cFlag];
  assign flagV = flags[vFlag];
  assign nEqV  = (flagN == flagV);

  always_comb begin
    case (cond)
      4'b0000: condPass = flagZ;                    // EQ
      4'b0001: condPass = !flagZ;                   // NE
      4'b0010: condPass = flagC;                    // CS
      4'b0011: condPass = !flagC;                   // CC
      4'b0100: condPass = flagN;                    // MI
      4'b0101: condPass = !flagN;                   // PL
      4'b0110: condPass = flagV;                    // VS
      4'b0111: condPass = !flagV;                   // VC
      4'b1000: condPass = flagC && !flagZ;          // HI
      4'b1001: condPass = !(flagC && !flagZ);       // LS
      4'b1010: condPass = nEqV;                     // GE
      4'b1011: condPass = !nEqV;                    // LT
      4'b1100: condPass = !flagZ && nEqV;           // GT
      4'b1101: condPass = !(!flagZ && nEqV);        // LE
      4'b1110: condPass = 1'b1;                     // AL
      default: condPass = 1'b0;                     // 1111 taken as never
    endcase
  end

endmodule

/* hdl/armStatus.sv */
module armStatus
  import armStatusPkg::*;
(
  input  logic                   clk,
  input  logic                   reset,
  input  logic [excCount-1:0]    excRequest,    // Raw exception requests
  input  logic [flagsWidth-1:0]  flagsNext,     // Flag update value
  input  logic                   flagsEnable,   // Flag update level
  input  logic                   readSaved,     // Show saved reg
  input  logic                   restoreSaved,  // Exception return
  input  logic [3:0]             cond,          // Condition to test
  output logic [statusWidth-1:0] statusData,    // Status view
  output logic                   excTaken,      // Exception accepted
  output logic [7:0]             excVector,     // Its vector offset
  output logic                   condPass       // Condition result
);

  logic [statusWidth-1:0] status;              // Live current status
  logic [excCount-1:0]    excSelect;           // One-hot winner
  logic                   irqDisable;
  logic                   fiqDisable;
  logic [flagsWidth-1:0]  flags;

  // Fields split out of the live status
  assign irqDisable = status[irqDisBit];
  assign fiqDisable = status[fiqDisBit];
  assign flags      = status[flagsLsb +: flagsWidth];

  exceptionPrioritizer i_prioritizer (
    .excRequest (excRequest),
    .irqDisable (irqDisable),
    .fiqDisable (fiqDisable),
    .excSelect  (excSelect),
    .excTaken   (excTaken),
    .excVector  (excVector)
  );

  statusRegs i_statusRegs (
    .clk          (clk),
    .reset        (reset),
    .excSelect    (excSelect),
    .excTaken     (excTaken),
    .flagsNext    (flagsNext),
    .flagsEnable  (flagsEnable),
    .readSaved    (readSaved),
    .restoreSaved (restoreSaved),
    .status       (status),
    .statusData   (statusData)
  );

  conditionCheck i_conditionCheck (
    .flags    (flags),
    .cond     (cond),
    .condPass (condPass)
  );

endmodule

/* tb/armStatusVectors.svh */
task automatic loadTable;
  // Columns are name, excRequest, flagsNext, flagsEnable, readSaved, restoreSaved, cond
  // and then expected excTaken, excVector, statusData and condPass after the edge
  addRow("reset state",         6'b000000, 4'h0, 0, 0, 0, 4'h0, 0, 8'h00, 12'h0D3, 0);
  addRow("fiq irq masked",      6'b110000, 4'h0, 0, 0, 0, 4'hE, 0, 8'h00, 12'h0D3, 1);
  addRow("load flags 0110",     6'b000000, 4'h6, 1, 0, 0, 4'h0, 0, 8'h00, 12'h6D3, 1);
  addRow("restore unmasks",     6'b000000, 4'h0, 0, 0, 1, 4'hE, 0, 8'h00, 12'h000, 1);
  addRow("load flags 1001",     6'b000000, 4'h9, 1, 0, 0, 4'hA, 0, 8'h00, 12'h900, 1);
  // Each entry then its saved copy
  addRow("enter fiq over irq",  6'b110000, 4'h0, 0, 0, 0, 4'hE, 1, 8'h1C, 12'h9D1, 1);
  addRow("fiq saved",           6'b000000, 4'h0, 0, 1, 0, 4'h4, 0, 8'h00, 12'h900, 1);
  addRow("return from fiq",     6'b000000, 4'h0, 0, 0, 1, 4'hE, 0, 8'h00, 12'h900, 1);
  addRow("load flags 0100",     6'b000000, 4'h4, 1, 0, 0, 4'h0, 0, 8'h00, 12'h400, 1);
  addRow("enter irq over rest", 6'b011101, 4'h0, 0, 0, 0, 4'hE, 1, 8'h18, 12'h492, 1);
  addRow("irq saved",           6'b000000, 4'h0, 0, 1, 0, 4'h1, 0, 8'h00, 12'h400, 0);
  addRow("irq masked",          6'b010000, 4'h0, 0, 0, 0, 4'hE, 0, 8'h00, 12'h492, 1);
  addRow("enter undef",         6'b001000, 4'h0, 0, 0, 0, 4'hE, 1, 8'h04, 12'h49B, 1);
  addRow("undef saved",         6'b000000, 4'h0, 0, 1, 0, 4'h5, 0, 8'h00, 12'h492, 1);
  // Flag load in the same cycle is dropped
  addRow("data beats flags",    6'b000010, 4'hF, 1, 0, 0, 4'h7, 1, 8'h10, 12'h497, 1);
  addRow("data saved",          6'b000000, 4'h0, 0, 1, 0, 4'h4, 0, 8'h00, 12'h49B, 0);
  addRow("enter swi",           6'b000001, 4'h0, 0, 0, 0, 4'hE, 1, 8'h08, 12'h493, 1);
  addRow("swi saved",           6'b000000, 4'h0, 0, 1, 0, 4'hE, 0, 8'h00, 12'h497, 1);
  addRow("load flags 0010",     6'b000000, 4'h2, 1, 0, 0, 4'h2, 0, 8'h00, 12'h293, 1);
  addRow("enter prefetch",      6'b000100, 4'h0, 0, 0, 0, 4'hE, 1, 8'h0C, 12'h297, 1);
  addRow("prefetch saved",      6'b000000, 4'h0, 0, 1, 0, 4'h3, 0, 8'h00, 12'h293, 0);
  // Simultaneous requests while IRQ is still masked
  addRow("data wins all",       6'b111111, 4'h0, 0, 0, 0, 4'hE, 1, 8'h10, 12'h297, 1);
  addRow("fiq wins rest",       6'b111101, 4'h0, 0, 0, 0, 4'hE, 1, 8'h1C, 12'h2D1, 1);
  addRow("prefetch over undef", 6'b111100, 4'h0, 0, 0, 0, 4'hE, 1, 8'h0C, 12'h2D7, 1);
  addRow("undef over swi",      6'b001001, 4'h0, 0, 0, 0, 4'hE, 1, 8'h04, 12'h2DB, 1);
  // Unwind the nested entries
  addRow("return to abort",     6'b000000, 4'h0, 0, 0, 1, 4'h2, 0, 8'h00, 12'h2D7, 1);
  addRow("return to fiq",       6'b000000, 4'h0, 0, 0, 1, 4'hE, 0, 8'h00, 12'h2D1, 1);
  addRow("return fiq unmasked", 6'b000000, 4'h0, 0, 0, 1, 4'hE, 0, 8'h00, 12'h297, 1);
  addRow("flags keep fields",   6'b000000, 4'hC, 1, 0, 0, 4'h8, 0, 8'h00, 12'hC97, 0);
  addRow("abort saved",         6'b000000, 4'h0, 0, 1, 0, 4'h9, 0, 8'h00, 12'h2D1, 1);
  addRow("status view",         6'b000000, 4'h0, 0, 0, 0, 4'hC, 0, 8'h00, 12'hC97, 0);
endtask

/* tb/armStatusTb.sv */
module armStatusTb
  import armStatusPkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int halfPeriod  = 10;                 // 20 ns clock
  localparam int resetCycles = 4;
  localparam int driveDelay  = 2;                  // Inputs change 2 ns after the edge
  localparam int sampleDelay = 15;                 // Lands 3 ns before the next edge
  localparam int waitSlack   = 10;                 // Extra polls before a timeout
  localparam int condSets    = 3;                  // Random flag values to sweep

  logic                   clk = 1'b0;
  logic                   reset;
  logic [excCount-1:0]    excRequest;
  logic [flagsWidth-1:0]  flagsNext;
  logic                   flagsEnable;
  logic                   readSaved;
  logic                   restoreSaved;
  logic [3:0]             cond;
  logic [statusWidth-1:0] statusData;
  logic                   excTaken;
  logic [7:0]             excVector;
  logic                   condPass;

  // Stimulus and expected columns, one entry per row
  string                  nameQ[$];
  logic [excCount-1:0]    reqQ[$];
  logic [flagsWidth-1:0]  flagsQ[$];
  logic                   enQ[$];
  logic                   readQ[$];
  logic                   restoreQ[$];
  logic [3:0]             condQ[$];
  logic                   takenQ[$];
  logic [7:0]             vecQ[$];
  logic [statusWidth-1:0] statusQ[$];
  logic                   passQ[$];

  int     cycleCount = 0;                          // Rising edges seen so far
  int     passCount  = 0;
  int     failCount  = 0;
  bit     timedOut   = 1'b0;
  integer seed;

  `include "armStatusVectors.svh"

  armStatus i_dut (
    .clk          (clk),
    .reset        (reset),
    .excRequest   (excRequest),
    .flagsNext    (flagsNext),
    .flagsEnable  (flagsEnable),
    .readSaved    (readSaved),
    .restoreSaved (restoreSaved),
    .cond         (cond),
    .statusData   (statusData),
    .excTaken     (excTaken),
    .excVector    (excVector),
    .condPass     (condPass)
  );

  always #halfPeriod clk = ~clk;

  always @(posedge clk) cycleCount <= cycleCount + 1;  // Settles after the edge

  task automatic addRow(input string name, input logic [excCount-1:0] req,
                        input logic [flagsWidth-1:0] flags, input logic en,
                        input logic rdSaved, input logic restore, input logic [3:0] code,
                        input logic taken, input logic [7:0] vector,
                        input logic [statusWidth-1:0] status, input logic pass);
    nameQ.push_back(name);
    reqQ.push_back(req);
    flagsQ.push_back(flags);
    enQ.push_back(en);
    readQ.push_back(rdSaved);
    restoreQ.push_back(restore);
    condQ.push_back(code);
    takenQ.push_back(taken);
    vecQ.push_back(vector);
    statusQ.push_back(status);
    passQ.push_back(pass);
  endtask

  // Polls in 1 ns steps so an edge is never read in its own time step
  task automatic waitCycles(input int cycles, input string what);
    int target;
    int guard;
    target = cycleCount + cycles;
    guard  = 0;
    while (cycleCount < target && guard < cycles * 2 * halfPeriod + waitSlack) begin
      #1;
      guard++;
    end
    if (cycleCount < target) begin
      $display("Timeout: the clock stopped while waiting for %0s", what);
      timedOut = 1'b1;
    end
  endtask

  // ARM rule: pairs of codes share a test, odd code inverts it
  function automatic logic condHolds(input logic [3:0] flags, input logic [3:0] code);
    logic n;
    logic z;
    logic c;
    logic v;
    logic base;
    n = flags[3];
    z = flags[2];
    c = flags[1];
    v = flags[0];
    if (code[3:1] == 3'd7) begin
      return !code[0];                             // AL true, 1111 never
    end
    case (code[3:1])
      3'd0:    base = z;
      3'd1:    base = c;
      3'd2:    base = n;
      3'd3:    base = v;
      3'd4:    base = c && !z;
      3'd5:    base = (n == v);
      default: base = !z && (n == v);
    endcase
    return base ^ code[0];
  endfunction

  // Sweeps all codes over seeded random flags, other status bits unchanged
  task automatic addConditionRows(input logic [statusWidth-1:0] baseStatus);
    int                    randWord;
    logic [flagsWidth-1:0] flagsRand;
    logic [3:0]            codeBits;
    for (int set = 0; set < condSets; set++) begin
      randWord  = $random(seed);
      flagsRand = randWord[3:0];
      for (int code = 0; code < 16; code++) begin
        codeBits = code[3:0];
        addRow($sformatf("cond %h flags %b", codeBits, flagsRand), '0, flagsRand, 1, 0, 0,
               codeBits, 0, 8'h00, {flagsRand, baseStatus[flagsLsb-1:0]},
               condHolds(flagsRand, codeBits));
      end
    end
  endtask

  task automatic driveRow(input int idx);
    excRequest   = reqQ[idx];
    flagsNext    = flagsQ[idx];
    flagsEnable  = enQ[idx];
    readSaved    = readQ[idx];
    restoreSaved = restoreQ[idx];
    cond         = condQ[idx];
  endtask

  initial begin : main
    logic rowFailed;
    seed         = 46554;
    reset        = 1'b1;
    excRequest   = '0;
    flagsNext    = '0;
    flagsEnable  = 1'b0;
    readSaved    = 1'b0;
    restoreSaved = 1'b0;
    cond         = 4'h0;
    loadTable();
    addConditionRows(statusQ[statusQ.size()-1]);   // Last fixed row shows live status
    waitCycles(resetCycles, "the end of reset");
    #(driveDelay - 1);
    reset = 1'b0;
    for (int i = 0; i < nameQ.size() && !timedOut; i++) begin
      rowFailed = 1'b0;
      driveRow(i);
      #sampleDelay;                                // Combinational outputs before the edge
      if (excTaken !== takenQ[i]) begin
        $display("Error %0s excTaken expected %b actual %b", nameQ[i], takenQ[i], excTaken);
        rowFailed = 1'b1;
      end
      if (excVector !== vecQ[i]) begin
        $display("Error %0s excVector expected %h actual %h", nameQ[i], vecQ[i], excVector);
        rowFailed = 1'b1;
      end
      waitCycles(1, $sformatf("the edge closing test %0s", nameQ[i]));
      if (timedOut) begin
        rowFailed = 1'b1;
      end else begin
        if (statusData !== statusQ[i]) begin
          $display("Error %0s statusData expected %h actual %h", nameQ[i], statusQ[i],
                   statusData);
          rowFailed = 1'b1;
        end
        if (condPass !== passQ[i]) begin
          $display("Error %0s condPass expected %b actual %b", nameQ[i], passQ[i], condPass);
          rowFailed = 1'b1;
        end
      end
      if (rowFailed) begin
        failCount++;
        $display("Test %0s: failed", nameQ[i]);
      end else begin
        passCount++;
        $display("Test %0s: ok", nameQ[i]);
      end
      #(driveDelay - 1);                           // Back to 2 ns after the edge
    end
    $display("Tests passed %0d failed %0d", passCount, failCount);
    if (failCount == 0 && !timedOut) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* build.f */
+incdir+tb
common/armStatusPkg.sv
hdl/exceptionPrioritizer.sv
statusRegs/statusRegs.sv
hdl/conditionCheck.sv
hdl/armStatus.sv
tb/armStatusTb.sv

/* Bender.yml */
package:
  name: armStatus

sources:
  - files:
      - common/armStatusPkg.sv
      - hdl/exceptionPrioritizer.sv
      - statusRegs/statusRegs.sv
      - hdl/conditionCheck.sv
      - hdl/armStatus.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/armStatusTb.sv
